/* ntsc_palette_ref.hex */
// One 24-bit NTSC RGB value per line, red in the top byte.
// Line order is {hue, lum}: hue-major, luminance-minor, 128 entries.
000000
404040
6c6c6c
909090
b0b0b0
c8c8c8
dcdcdc
ececec
444400
646410
848424
a0a034
b8b840
d0d050
e8e85c
fcfc68
702800
844414
985c28
ac783c
bc8c4c
cca05c
dcb468
ecc878
841800
983418
ac5030
c06848
d0805c
e09470
eca880
fcbc94
880000
9c2020
b03c3c
c05858
d07070
e08888
eca0a0
fcb4b4
78005c
8c2074
a03c88
b0589c
c070b0
d084c0
dc9cd0
ecb0e0
480078
602090
783ca4
8c58b8
a070cc
b484dc
c49cec
d4b0fc
140084
302098
4c3cac
6858c0
7c70d0
9488e0
a8a0ec
bcb4fc
000088
1c209c
3840b0
505cc0
6874d0
7c8ce0
90a4ec
a4b8fc
00187c
1c3890
3854a8
5070bc
6888cc
7c9cdc
90b4ec
a4c8fc
002c5c
1c4c78
386890
5084ac
689cc0
7cb4d4
90cce8
a4e0fc
003c2c
1c5c48
387c64
509c80
68b494
7cd0ac
90e4c0
a4fcd4
003c00
205c20
407c40
5c9c5c
74b474
8cd08c
a4e4a4
b8fcb8
143800
345c1c
507c38
6c9850
84b468
9ccc7c
b4e490
c8fca4
2c3000
4c501c
687034
848c4c
9ca864
b4c078
ccd488
e0ec9c
442800
644818
846830
a08444
b89c58
d0b46c
e8cc7c
fce08c

/* sources.f */
+incdir+.
tia_color_pkg.sv
tia_video_pkg.sv
tia_color_regs.sv
ntsc_palette.sv
tia_pixel_priority.sv
tia_color_out.sv
tb_clock_gen.sv
tb_tia_color_out.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TIA color output stage simulation with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module tb_tia_color_out \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  exit 0
fi
exit 1

/* tb_tia_color_out.sv */
//##########################################################
// TIA color output stage testbench
//##########################################################
`timescale 1ns/1ps
`include "tia_defines.svh"

module tb_tia_color_out;

  localparam int RAND_CYCLES = 100;
  localparam int TEST_CYCLES = 10 + 8 + 257 + 5 * RAND_CYCLES + 12 + 3;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                       clk;
  logic                       arst_n;
  logic                       reg_we;
  tia_video_pkg::reg_addr_t   reg_addr;
  tia_color_pkg::color_code_t reg_data;
  logic                       p0_hit;
  logic                       p1_hit;
  logic                       pf_hit;
  logic                       pf_priority;
  logic                       score_mode;
  logic                       right_half;
  logic                       blank;
  tia_color_pkg::rgb_t        rgb;

  tia_color_pkg::rgb_t        pal_mem [0:127];
  tia_color_pkg::color_code_t model_regs [`TIA_NUM_COLOR_REGS];
  tia_color_pkg::rgb_t        exp_rgb;
  logic                       armed = 1'b0;
  logic [31:0]                lfsr;
  int                         error_count = 0;
  int                         check_count = 0;
  int                         cycle_count = 0;

  tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

  tia_color_out uut (
    .clk(clk), .arst_n(arst_n), .reg_we(reg_we), .reg_addr(reg_addr), .reg_data(reg_data),
    .p0_hit(p0_hit), .p1_hit(p1_hit), .pf_hit(pf_hit), .pf_priority(pf_priority),
    .score_mode(score_mode), .right_half(right_half), .blank(blank), .rgb(rgb)
  );

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] next_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  // Expected pixel from the model registers and the palette table.
  function automatic tia_color_pkg::rgb_t expected_pixel(input logic p0, input logic p1,
      input logic pf, input logic prio, input logic score, input logic right, input logic blk);
    tia_color_pkg::color_code_t code;
    if (blk)
      return '0;
    if (prio)
    begin
      if (pf)      code = model_regs[`TIA_REG_COLUPF];
      else if (p0) code = model_regs[`TIA_REG_COLUP0];
      else if (p1) code = model_regs[`TIA_REG_COLUP1];
      else         code = model_regs[`TIA_REG_COLUBK];
    end
    else
    begin
      if (p0)         code = model_regs[`TIA_REG_COLUP0];
      else if (p1)    code = model_regs[`TIA_REG_COLUP1];
      else if (pf && score)
        code = right ? model_regs[`TIA_REG_COLUP1] : model_regs[`TIA_REG_COLUP0];
      else if (pf)    code = model_regs[`TIA_REG_COLUPF];
      else            code = model_regs[`TIA_REG_COLUBK];
    end
    return pal_mem[code[7:1]];  // Bit 0 plays no part.
  endfunction

  // Pixel sampled at this edge uses the registers before the write.
  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `TIA_NUM_COLOR_REGS; i++)
        model_regs[i] = '0;
      armed = 1'b0;
    end
    else
    begin
      exp_rgb = expected_pixel(p0_hit, p1_hit, pf_hit, pf_priority, score_mode,
                               right_half, blank);
      if (reg_we)
        model_regs[reg_addr] = reg_data;
      armed = 1'b1;
    end
  end

  always @(negedge clk)
  begin
    if (armed)
    begin
      check_count++;
      assert (rgb === exp_rgb)
      else
      begin
        error_count++;
        $display("** Error at %0t: rgb expected %06h, got %06h", $time, exp_rgb, rgb);
      end
    end
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic drive(input logic we, input tia_video_pkg::reg_addr_t addr,
                       input tia_color_pkg::color_code_t data, input logic [6:0] pix);
    @(posedge clk);
    reg_we   <= we;
    reg_addr <= addr;
    reg_data <= data;
    {blank, right_half, score_mode, pf_priority, pf_hit, p1_hit, p0_hit} <= pix;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 2'd0, 8'd0, 7'd0);
  endtask

  // Random write and random hits, pix order {blank, right, score, prio, pf, p1, p0}.
  task automatic random_cycle(input logic prio, input logic score, input logic blank_v);
    logic [31:0] r;
    r = next_bits(15);
    drive(r[14], r[13:12], r[11:4], {blank_v, r[0], score, prio, r[3:1]});
  endtask

  initial
  begin
    logic [31:0] s;
    logic [2:0]  hits;
    lfsr        = 32'hb8e8;
    reg_we      = 1'b0;
    reg_addr    = '0;
    reg_data    = '0;
    p0_hit      = 1'b0;
    p1_hit      = 1'b0;
    pf_hit      = 1'b0;
    pf_priority = 1'b0;
    score_mode  = 1'b0;
    right_half  = 1'b0;
    blank       = 1'b0;
    $readmemh("ntsc_palette_ref.hex", pal_mem);
    @(posedge arst_n);
    @(negedge clk);
    assert (rgb == '0)
    else
    begin
      error_count++;
      $display("** Error at %0t: rgb not black out of reset, got %06h", $time, rgb);
    end
    idle(8);
    //##########################################################
    // Palette sweep through the background register
    //##########################################################
    for (int c = 0; c < 256; c++)
      drive(1'b1, `TIA_REG_COLUBK, 8'(c), 7'd0);
    idle(1);
    repeat (2 * RAND_CYCLES) random_cycle(1'b0, 1'b0, 1'b0);
    repeat (RAND_CYCLES)
    begin
      s = next_bits(1);
      random_cycle(1'b1, s[0], 1'b0);  // Playfield first.
    end
    repeat (RAND_CYCLES) random_cycle(1'b0, 1'b1, 1'b0);
    repeat (RAND_CYCLES)
    begin
      s = next_bits(2);
      random_cycle(s[1], s[0], 1'b1);
    end
    //##########################################################
    // Write in the same cycle as a pixel of that register
    //##########################################################
    for (int a = 0; a < `TIA_NUM_COLOR_REGS; a++)
    begin
      hits = (a == 3) ? 3'b000 : (3'b001 << a);
      drive(1'b1, 2'(a), {4'(a + 4), 3'd2, 1'b0}, 7'd0);
      drive(1'b1, 2'(a), {4'(a + 8), 3'd5, 1'b1}, {4'b0000, hits});
      drive(1'b0, 2'(a), 8'd0, {4'b0000, hits});
    end
    idle(3);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
//##########################################################
// Testbench clock and reset
//##########################################################
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

/* tia_color_out.sv */
//##########################################################
// TIA color output stage
//##########################################################
`timescale 1ns/1ps
`include "tia_defines.svh"

module tia_color_out (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        reg_we,
  input  tia_video_pkg::reg_addr_t    reg_addr,
  input  tia_color_pkg::color_code_t  reg_data,
  input  logic                        p0_hit,
  input  logic                        p1_hit,
  input  logic                        pf_hit,
  input  logic                        pf_priority,
  input  logic                        score_mode,
  input  logic                        right_half,
  input  logic                        blank,
  output tia_color_pkg::rgb_t         rgb
);

  tia_color_pkg::color_code_t colu    [`TIA_NUM_COLOR_REGS];
  tia_color_pkg::rgb_t        pal_rgb [`TIA_NUM_COLOR_REGS];

  tia_color_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .reg_we   (reg_we),
    .reg_addr (reg_addr),
    .reg_data (reg_data),
    .colu     (colu)
  );

  // One palette per color register.
  for (genvar i = 0; i < `TIA_NUM_COLOR_REGS; i++)
  begin : g_palette
    ntsc_palette u_palette (
      .color (colu[i]),
      .rgb   (pal_rgb[i])
    );
  end

  tia_pixel_priority u_priority (
    .clk         (clk),
    .arst_n      (arst_n),
    .pal_rgb     (pal_rgb),
    .p0_hit      (p0_hit),
    .p1_hit      (p1_hit),
    .pf_hit      (pf_hit),
    .pf_priority (pf_priority),
    .score_mode  (score_mode),
    .right_half  (right_half),
    .blank       (blank),
    .rgb         (rgb)
  );

endmodule

/* tia_pixel_priority.sv */
//##########################################################
// TIA pixel priority and blanking
//##########################################################
`timescale 1ns/1ps
`include "tia_defines.svh"

module tia_pixel_priority (
  input  logic                 clk,
  input  logic                 arst_n,
  input  tia_color_pkg::rgb_t  pal_rgb [`TIA_NUM_COLOR_REGS],
  input  logic                 p0_hit,
  input  logic                 p1_hit,
  input  logic                 pf_hit,
  input  logic                 pf_priority,
  input  logic                 score_mode,
  input  logic                 right_half,
  input  logic                 blank,
  output tia_color_pkg::rgb_t  rgb
);

  tia_video_pkg::pix_src_e src;
  tia_video_pkg::pix_src_e pf_src;

  // Score mode paints the playfield in the player colors.
  assign pf_src = score_mode ? (right_half ? tia_video_pkg::SRC_P1 : tia_video_pkg::SRC_P0)
                             : tia_video_pkg::SRC_PF;

  always_comb
  begin
    if (pf_priority)
    begin
      if (pf_hit)      src = tia_video_pkg::SRC_PF;
      else if (p0_hit) src = tia_video_pkg::SRC_P0;
      else if (p1_hit) src = tia_video_pkg::SRC_P1;
      else             src = tia_video_pkg::SRC_BK;
    end
    else
    begin
      if (p0_hit)      src = tia_video_pkg::SRC_P0;
      else if (p1_hit) src = tia_video_pkg::SRC_P1;
      else if (pf_hit) src = pf_src;
      else             src = tia_video_pkg::SRC_BK;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rgb <= '0;
    else
      rgb <= blank ? '0 : pal_rgb[src];  // One pixel of latency.
  end

  //##########################################################
  // Checks
  //##########################################################
  a_inputs_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown({p0_hit, p1_hit, pf_hit, pf_priority, score_mode, right_half, blank})
  ) else $error("unknown pixel input");

endmodule

/* ntsc_palette.sv */
//##########################################################
// NTSC palette lookup
//##########################################################
`timescale 1ns/1ps

module ntsc_palette (
  input  tia_color_pkg::color_code_t  color,
  output tia_color_pkg::rgb_t         rgb
);

  tia_color_pkg::hue_e hue;
  tia_color_pkg::lum_t lum;

  assign hue = tia_color_pkg::hue_e'(color[7:4]);
  assign lum = color[3:1];  // Bit 0 has no effect.

  //##########################################################
  // Hue major, luminance minor
  //##########################################################
  always_comb
  begin
    rgb = '0;
    case ({hue, lum})
      {tia_color_pkg::HUE_GREY, 3'd0}:         rgb = 24'h000000;
      {tia_color_pkg::HUE_GREY, 3'd1}:         rgb = 24'h404040;
      {tia_color_pkg::HUE_GREY, 3'd2}:         rgb = 24'h6c6c6c;
      {tia_color_pkg::HUE_GREY, 3'd3}:         rgb = 24'h909090;
      {tia_color_pkg::HUE_GREY, 3'd4}:         rgb = 24'hb0b0b0;
      {tia_color_pkg::HUE_GREY, 3'd5}:         rgb = 24'hc8c8c8;
      {tia_color_pkg::HUE_GREY, 3'd6}:         rgb = 24'hdcdcdc;
      {tia_color_pkg::HUE_GREY, 3'd7}:         rgb = 24'hececec;
      {tia_color_pkg::HUE_GOLD, 3'd0}:         rgb = 24'h444400;
      {tia_color_pkg::HUE_GOLD, 3'd1}:         rgb = 24'h646410;
      {tia_color_pkg::HUE_GOLD, 3'd2}:         rgb = 24'h848424;
      {tia_color_pkg::HUE_GOLD, 3'd3}:         rgb = 24'ha0a034;
      {tia_color_pkg::HUE_GOLD, 3'd4}:         rgb = 24'hb8b840;
      {tia_color_pkg::HUE_GOLD, 3'd5}:         rgb = 24'hd0d050;
      {tia_color_pkg::HUE_GOLD, 3'd6}:         rgb = 24'he8e85c;
      {tia_color_pkg::HUE_GOLD, 3'd7}:         rgb = 24'hfcfc68;
      {tia_color_pkg::HUE_ORANGE, 3'd0}:       rgb = 24'h702800;
      {tia_color_pkg::HUE_ORANGE, 3'd1}:       rgb = 24'h844414;
      {tia_color_pkg::HUE_ORANGE, 3'd2}:       rgb = 24'h985c28;
      {tia_color_pkg::HUE_ORANGE, 3'd3}:       rgb = 24'hac783c;
      {tia_color_pkg::HUE_ORANGE, 3'd4}:       rgb = 24'hbc8c4c;
      {tia_color_pkg::HUE_ORANGE, 3'd5}:       rgb = 24'hcca05c;
      {tia_color_pkg::HUE_ORANGE, 3'd6}:       rgb = 24'hdcb468;
      {tia_color_pkg::HUE_ORANGE, 3'd7}:       rgb = 24'hecc878;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd0}:   rgb = 24'h841800;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd1}:   rgb = 24'h983418;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd2}:   rgb = 24'hac5030;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd3}:   rgb = 24'hc06848;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd4}:   rgb = 24'hd0805c;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd5}:   rgb = 24'he09470;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd6}:   rgb = 24'heca880;
      {tia_color_pkg::HUE_RED_ORANGE, 3'd7}:   rgb = 24'hfcbc94;
      {tia_color_pkg::HUE_PINK, 3'd0}:         rgb = 24'h880000;
      {tia_color_pkg::HUE_PINK, 3'd1}:         rgb = 24'h9c2020;
      {tia_color_pkg::HUE_PINK, 3'd2}:         rgb = 24'hb03c3c;
      {tia_color_pkg::HUE_PINK, 3'd3}:         rgb = 24'hc05858;
      {tia_color_pkg::HUE_PINK, 3'd4}:         rgb = 24'hd07070;
      {tia_color_pkg::HUE_PINK, 3'd5}:         rgb = 24'he08888;
      {tia_color_pkg::HUE_PINK, 3'd6}:         rgb = 24'heca0a0;
      {tia_color_pkg::HUE_PINK, 3'd7}:         rgb = 24'hfcb4b4;
      {tia_color_pkg::HUE_PURPLE, 3'd0}:       rgb = 24'h78005c;
      {tia_color_pkg::HUE_PURPLE, 3'd1}:       rgb = 24'h8c2074;
      {tia_color_pkg::HUE_PURPLE, 3'd2}:       rgb = 24'ha03c88;
      {tia_color_pkg::HUE_PURPLE, 3'd3}:       rgb = 24'hb0589c;
      {tia_color_pkg::HUE_PURPLE, 3'd4}:       rgb = 24'hc070b0;
      {tia_color_pkg::HUE_PURPLE, 3'd5}:       rgb = 24'hd084c0;
      {tia_color_pkg::HUE_PURPLE, 3'd6}:       rgb = 24'hdc9cd0;
      {tia_color_pkg::HUE_PURPLE, 3'd7}:       rgb = 24'hecb0e0;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd0}:  rgb = 24'h480078;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd1}:  rgb = 24'h602090;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd2}:  rgb = 24'h783ca4;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd3}:  rgb = 24'h8c58b8;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd4}:  rgb = 24'ha070cc;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd5}:  rgb = 24'hb484dc;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd6}:  rgb = 24'hc49cec;
      {tia_color_pkg::HUE_PURPLE_BLUE, 3'd7}:  rgb = 24'hd4b0fc;
      {tia_color_pkg::HUE_BLUE, 3'd0}:         rgb = 24'h140084;
      {tia_color_pkg::HUE_BLUE, 3'd1}:         rgb = 24'h302098;
      {tia_color_pkg::HUE_BLUE, 3'd2}:         rgb = 24'h4c3cac;
      {tia_color_pkg::HUE_BLUE, 3'd3}:         rgb = 24'h6858c0;
      {tia_color_pkg::HUE_BLUE, 3'd4}:         rgb = 24'h7c70d0;
      {tia_color_pkg::HUE_BLUE, 3'd5}:         rgb = 24'h9488e0;
      {tia_color_pkg::HUE_BLUE, 3'd6}:         rgb = 24'ha8a0ec;
      {tia_color_pkg::HUE_BLUE, 3'd7}:         rgb = 24'hbcb4fc;
      {tia_color_pkg::HUE_BLUE1, 3'd0}:        rgb = 24'h000088;
      {tia_color_pkg::HUE_BLUE1, 3'd1}:        rgb = 24'h1c209c;
      {tia_color_pkg::HUE_BLUE1, 3'd2}:        rgb = 24'h3840b0;
      {tia_color_pkg::HUE_BLUE1, 3'd3}:        rgb = 24'h505cc0;
      {tia_color_pkg::HUE_BLUE1, 3'd4}:        rgb = 24'h6874d0;
      {tia_color_pkg::HUE_BLUE1, 3'd5}:        rgb = 24'h7c8ce0;
      {tia_color_pkg::HUE_BLUE1, 3'd6}:        rgb = 24'h90a4ec;
      {tia_color_pkg::HUE_BLUE1, 3'd7}:        rgb = 24'ha4b8fc;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd0}:   rgb = 24'h00187c;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd1}:   rgb = 24'h1c3890;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd2}:   rgb = 24'h3854a8;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd3}:   rgb = 24'h5070bc;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd4}:   rgb = 24'h6888cc;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd5}:   rgb = 24'h7c9cdc;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd6}:   rgb = 24'h90b4ec;
      {tia_color_pkg::HUE_LIGHT_BLUE, 3'd7}:   rgb = 24'ha4c8fc;
      {tia_color_pkg::HUE_TURQUOISE, 3'd0}:    rgb = 24'h002c5c;
      {tia_color_pkg::HUE_TURQUOISE, 3'd1}:    rgb = 24'h1c4c78;
      {tia_color_pkg::HUE_TURQUOISE, 3'd2}:    rgb = 24'h386890;
      {tia_color_pkg::HUE_TURQUOISE, 3'd3}:    rgb = 24'h5084ac;
      {tia_color_pkg::HUE_TURQUOISE, 3'd4}:    rgb = 24'h689cc0;
      {tia_color_pkg::HUE_TURQUOISE, 3'd5}:    rgb = 24'h7cb4d4;
      {tia_color_pkg::HUE_TURQUOISE, 3'd6}:    rgb = 24'h90cce8;
      {tia_color_pkg::HUE_TURQUOISE, 3'd7}:    rgb = 24'ha4e0fc;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd0}:   rgb = 24'h003c2c;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd1}:   rgb = 24'h1c5c48;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd2}:   rgb = 24'h387c64;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd3}:   rgb = 24'h509c80;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd4}:   rgb = 24'h68b494;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd5}:   rgb = 24'h7cd0ac;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd6}:   rgb = 24'h90e4c0;
      {tia_color_pkg::HUE_GREEN_BLUE, 3'd7}:   rgb = 24'ha4fcd4;
      {tia_color_pkg::HUE_GREEN, 3'd0}:        rgb = 24'h003c00;
      {tia_color_pkg::HUE_GREEN, 3'd1}:        rgb = 24'h205c20;
      {tia_color_pkg::HUE_GREEN, 3'd2}:        rgb = 24'h407c40;
      {tia_color_pkg::HUE_GREEN, 3'd3}:        rgb = 24'h5c9c5c;
      {tia_color_pkg::HUE_GREEN, 3'd4}:        rgb = 24'h74b474;
      {tia_color_pkg::HUE_GREEN, 3'd5}:        rgb = 24'h8cd08c;
      {tia_color_pkg::HUE_GREEN, 3'd6}:        rgb = 24'ha4e4a4;
      {tia_color_pkg::HUE_GREEN, 3'd7}:        rgb = 24'hb8fcb8;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd0}: rgb = 24'h143800;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd1}: rgb = 24'h345c1c;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd2}: rgb = 24'h507c38;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd3}: rgb = 24'h6c9850;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd4}: rgb = 24'h84b468;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd5}: rgb = 24'h9ccc7c;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd6}: rgb = 24'hb4e490;
      {tia_color_pkg::HUE_YELLOW_GREEN, 3'd7}: rgb = 24'hc8fca4;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd0}: rgb = 24'h2c3000;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd1}: rgb = 24'h4c501c;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd2}: rgb = 24'h687034;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd3}: rgb = 24'h848c4c;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd4}: rgb = 24'h9ca864;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd5}: rgb = 24'hb4c078;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd6}: rgb = 24'hccd488;
      {tia_color_pkg::HUE_ORANGE_GREEN, 3'd7}: rgb = 24'he0ec9c;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd0}:  rgb = 24'h442800;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd1}:  rgb = 24'h644818;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd2}:  rgb = 24'h846830;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd3}:  rgb = 24'ha08444;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd4}:  rgb = 24'hb89c58;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd5}:  rgb = 24'hd0b46c;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd6}:  rgb = 24'he8cc7c;
      {tia_color_pkg::HUE_LIGHT_GREEN, 3'd7}:  rgb = 24'hfce08c;
    endcase
  end

endmodule

/* tia_color_regs.sv */
//##########################################################
// TIA color registers
//##########################################################
`timescale 1ns/1ps
`include "tia_defines.svh"

module tia_color_regs (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        reg_we,
  input  tia_video_pkg::reg_addr_t    reg_addr,
  input  tia_color_pkg::color_code_t  reg_data,
  output tia_color_pkg::color_code_t  colu [`TIA_NUM_COLOR_REGS]
);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `TIA_NUM_COLOR_REGS; i++)
      begin
        colu[i] <= '0;  // Grey at lum 0, black.
      end
    end
    else if (reg_we)
    begin
      colu[reg_addr] <= reg_data;
    end
  end

  //##########################################################
  // Checks
  //##########################################################
  a_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    reg_we |-> !$isunknown(reg_addr)
  ) else $error("color register write with unknown address");

endmodule

/* tia_video_pkg.sv */
//##########################################################
// TIA video path types
//##########################################################
`include "tia_defines.svh"

package tia_video_pkg;

  typedef logic [1:0] reg_addr_t;

  // Pixel source matches the register that supplies its color.
  typedef enum reg_addr_t {
    SRC_P0 = `TIA_REG_COLUP0,
    SRC_P1 = `TIA_REG_COLUP1,
    SRC_PF = `TIA_REG_COLUPF,
    SRC_BK = `TIA_REG_COLUBK
  } pix_src_e;

endpackage

/* tia_color_pkg.sv */
//##########################################################
// TIA color types
//##########################################################
`include "tia_defines.svh"

package tia_color_pkg;

  typedef logic [3:0]  hue_t;
  typedef logic [2:0]  lum_t;
  typedef logic [7:0]  color_code_t;  // Hue, luminance, unused bit 0.
  typedef logic [23:0] rgb_t;         // Red in the top byte.

  typedef enum hue_t {
    HUE_GREY         = `TIA_HUE_GREY,
    HUE_GOLD         = `TIA_HUE_GOLD,
    HUE_ORANGE       = `TIA_HUE_ORANGE,
    HUE_RED_ORANGE   = `TIA_HUE_RED_ORANGE,
    HUE_PINK         = `TIA_HUE_PINK,
    HUE_PURPLE       = `TIA_HUE_PURPLE,
    HUE_PURPLE_BLUE  = `TIA_HUE_PURPLE_BLUE,
    HUE_BLUE         = `TIA_HUE_BLUE,
    HUE_BLUE1        = `TIA_HUE_BLUE1,
    HUE_LIGHT_BLUE   = `TIA_HUE_LIGHT_BLUE,
    HUE_TURQUOISE    = `TIA_HUE_TURQUOISE,
    HUE_GREEN_BLUE   = `TIA_HUE_GREEN_BLUE,
    HUE_GREEN        = `TIA_HUE_GREEN,
    HUE_YELLOW_GREEN = `TIA_HUE_YELLOW_GREEN,
    HUE_ORANGE_GREEN = `TIA_HUE_ORANGE_GREEN,
    HUE_LIGHT_GREEN  = `TIA_HUE_LIGHT_GREEN
  } hue_e;

endpackage

/* tia_defines.svh */
//##########################################################
// TIA color stage constants
//##########################################################
`ifndef TIA_DEFINES_SVH
`define TIA_DEFINES_SVH

`define TIA_NUM_COLOR_REGS 4

`define TIA_REG_COLUP0 2'd0
`define TIA_REG_COLUP1 2'd1
`define TIA_REG_COLUPF 2'd2
`define TIA_REG_COLUBK 2'd3

`define TIA_HUE_GREY         4'd0
`define TIA_HUE_GOLD         4'd1
`define TIA_HUE_ORANGE       4'd2
`define TIA_HUE_RED_ORANGE   4'd3
`define TIA_HUE_PINK         4'd4
`define TIA_HUE_PURPLE       4'd5
`define TIA_HUE_PURPLE_BLUE  4'd6
`define TIA_HUE_BLUE         4'd7
`define TIA_HUE_BLUE1        4'd8
`define TIA_HUE_LIGHT_BLUE   4'd9
`define TIA_HUE_TURQUOISE    4'd10
`define TIA_HUE_GREEN_BLUE   4'd11
`define TIA_HUE_GREEN        4'd12
`define TIA_HUE_YELLOW_GREEN 4'd13
`define TIA_HUE_ORANGE_GREEN 4'd14
`define TIA_HUE_LIGHT_GREEN  4'd15

`endif
